//--- common/dma_cluster_pkg.sv
/* DMA cluster front end package
   Geometry of the interleaved TCDM and the request, piece and status types */
`default_nettype none

package dma_cluster_pkg;

  // Cluster geometry
  localparam int unsigned NumGroups     = 4;
  localparam int unsigned BanksPerGroup = 4;
  localparam int unsigned BankBytes     = 4;
  localparam int unsigned GroupBytes    = BanksPerGroup * BankBytes;
  localparam int unsigned RowBytes      = GroupBytes * NumGroups; // One interleaving row

  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned LenWidth      = 16;
  localparam int unsigned GroupIdxWidth = $clog2(NumGroups);

  // Completion tracking
  localparam int unsigned TrackDepth    = 16;
  localparam int unsigned TrackPtrWidth = $clog2(TrackDepth);
  localparam int unsigned TrackCntWidth = $clog2(TrackDepth) + 2; // Headroom for early dones

  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [LenWidth-1:0]  len_t;

  // TCDM region
  localparam addr_t       TcdmBaseAddr = 32'h0000_0000;
  localparam int unsigned TcdmSize     = 64 * 1024;

  // Whole transfer or group piece
  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  num_bytes;
  } dma_req_t;

  typedef struct packed {
    dma_req_t req;
    logic     last;   // Final piece of the transfer
  } dma_row_piece_t;

  typedef logic [NumGroups-1:0] group_mask_t;

  typedef struct packed {
    logic trans_complete;
    logic backend_idle;
  } dma_meta_t;

endpackage : dma_cluster_pkg

`default_nettype wire

//--- dma/dma_spill_reg.sv
/* Two-entry valid/ready register slice for DMA request words
   Both the data path and the ready path are registered */
`timescale 1ns/1ps
`default_nettype none

module dma_spill_reg (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  dma_cluster_pkg::dma_req_t data_i,
  input  logic                      valid_i,
  output logic                      ready_o,
  output dma_cluster_pkg::dma_req_t data_o,
  output logic                      valid_o,
  input  logic                      ready_i
);
  import dma_cluster_pkg::*;

  dma_req_t a_data_q;
  dma_req_t b_data_q;
  logic     a_full_q, a_full_d;
  logic     b_full_q, b_full_d;
  logic     ready_q;
  logic     a_fill, a_drain, b_fill, b_drain;

  assign a_fill  = valid_i && ready_q;
  assign a_drain = a_full_q && !b_full_q;  // Out or into the spill entry
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  assign a_full_d = a_fill || (a_full_q && !a_drain);
  assign b_full_d = b_fill || (b_full_q && !b_drain);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
      ready_q  <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
      ready_q  <= !(a_full_d && b_full_d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // Spill entry always holds the older word
  assign data_o  = b_full_q ? b_data_q : a_data_q;
  assign valid_o = a_full_q || b_full_q;
  assign ready_o = ready_q;

  a_hold_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule : dma_spill_reg

`default_nettype wire

//--- dma/dma_row_splitter.sv
/* Row splitter of the DMA front end
   Cuts a transfer into pieces that never cross an interleaving row */
`timescale 1ns/1ps
`default_nettype none

module dma_row_splitter (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  dma_cluster_pkg::dma_req_t       req_i,
  input  logic                            req_valid_i,
  output logic                            req_ready_o,
  output dma_cluster_pkg::dma_row_piece_t piece_o,
  output logic                            piece_valid_o,
  input  logic                            piece_ready_i
);
  import dma_cluster_pkg::*;

  dma_req_t cur_q;    // Remaining part of the transfer
  logic     active_q;
  len_t     room;
  len_t     chunk;
  logic     is_last;
  logic     req_hs;
  logic     piece_hs;

  // Bytes left until the next row boundary
  assign room    = len_t'(RowBytes - (cur_q.dst % RowBytes));
  assign is_last = (cur_q.num_bytes <= room);
  assign chunk   = is_last ? cur_q.num_bytes : room;

  assign piece_o.req.src       = cur_q.src;
  assign piece_o.req.dst       = cur_q.dst;
  assign piece_o.req.num_bytes = chunk;
  assign piece_o.last          = is_last;
  assign piece_valid_o         = active_q;

  assign piece_hs    = piece_valid_o && piece_ready_i;
  // Next transfer loads while the last piece leaves
  assign req_ready_o = !active_q || (piece_hs && is_last);
  assign req_hs      = req_valid_i && req_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
    end else if (req_hs) begin
      active_q <= 1'b1;
    end else if (piece_hs && is_last) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      cur_q <= req_i;
    end else if (piece_hs) begin
      cur_q.src       <= cur_q.src + chunk;
      cur_q.dst       <= cur_q.dst + chunk;
      cur_q.num_bytes <= cur_q.num_bytes - chunk;
    end
  end

  // Every destination is expected inside the TCDM region
  a_req_in_tcdm: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_hs && (req_i.num_bytes != '0) |->
      (req_i.dst >= TcdmBaseAddr) &&
      (({1'b0, req_i.dst} + (AddrWidth+1)'(req_i.num_bytes)) <=
       (AddrWidth+1)'(TcdmBaseAddr + TcdmSize)));

  a_piece_in_row: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    piece_valid_o |-> (piece_o.req.dst % RowBytes) + piece_o.req.num_bytes <= RowBytes);

endmodule : dma_row_splitter

`default_nettype wire

//--- dma/dma_group_distributor.sv
/* Group distributor of the DMA front end
   Cuts row pieces at group stripes and steers each stripe to its group */
`timescale 1ns/1ps
`default_nettype none

module dma_group_distributor (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  dma_cluster_pkg::dma_row_piece_t piece_i,
  input  logic                            piece_valid_i,
  output logic                            piece_ready_o,
  output dma_cluster_pkg::dma_req_t [dma_cluster_pkg::NumGroups-1:0] group_req_o,
  output dma_cluster_pkg::group_mask_t    group_valid_o,
  input  dma_cluster_pkg::group_mask_t    group_ready_i,
  output logic                            track_push_o,
  output dma_cluster_pkg::group_mask_t    track_mask_o,
  output logic                            track_last_o,
  input  logic                            track_full_i
);
  import dma_cluster_pkg::*;

  dma_req_t                 cur_q;
  logic                     last_q;   // Row piece ends the transfer
  group_mask_t              mask_q;   // Groups used so far
  logic                     active_q;
  len_t                     room;
  len_t                     chunk;
  logic                     last_stripe;
  logic [GroupIdxWidth-1:0] target;
  logic                     out_valid;
  logic                     advance;
  logic                     piece_hs;

  assign room        = len_t'(GroupBytes - (cur_q.dst % GroupBytes));
  assign last_stripe = (cur_q.num_bytes <= room);
  assign chunk       = last_stripe ? cur_q.num_bytes : room;
  assign target      = GroupIdxWidth'((cur_q.dst / GroupBytes) % NumGroups);

  // The last stripe waits for a free tracker slot
  assign out_valid = active_q && !(last_stripe && track_full_i);
  assign advance   = out_valid && group_ready_i[target];

  for (genvar g = 0; g < NumGroups; g++) begin : gen_group_out
    assign group_req_o[g].src       = cur_q.src;
    assign group_req_o[g].dst       = cur_q.dst;
    assign group_req_o[g].num_bytes = chunk;
  end : gen_group_out

  assign group_valid_o = out_valid ? (group_mask_t'(1) << target) : '0;

  assign track_push_o = advance && last_stripe;
  assign track_mask_o = mask_q | (group_mask_t'(1) << target);
  assign track_last_o = last_q;

  assign piece_ready_o = (!active_q || track_push_o) && !track_full_i;
  assign piece_hs      = piece_valid_i && piece_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      active_q <= 1'b0;
    end else if (piece_hs) begin
      active_q <= 1'b1;
    end else if (track_push_o) begin
      active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (piece_hs) begin
      cur_q  <= piece_i.req;
      last_q <= piece_i.last;
      mask_q <= '0;
    end else if (advance) begin
      cur_q.src       <= cur_q.src + chunk;
      cur_q.dst       <= cur_q.dst + chunk;
      cur_q.num_bytes <= cur_q.num_bytes - chunk;
      mask_q          <= track_mask_o;
    end
  end

  a_one_group: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(group_valid_o));

endmodule : dma_group_distributor

`default_nettype wire

//--- dma/dma_completion_tracker.sv
/* Completion tracker of the DMA front end
   Matches group done strobes with outstanding row pieces, builds cluster status */
`timescale 1ns/1ps
`default_nettype none

module dma_completion_tracker (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         push_i,
  input  dma_cluster_pkg::group_mask_t mask_i,
  input  logic                         last_i,
  output logic                         full_o,
  input  dma_cluster_pkg::group_mask_t group_done_i,
  input  logic                         busy_i,
  output dma_cluster_pkg::dma_meta_t   dma_meta_o
);
  import dma_cluster_pkg::*;

  group_mask_t              mask_mem [TrackDepth];
  logic                     last_mem [TrackDepth];
  logic [TrackPtrWidth-1:0] wr_ptr_q, rd_ptr_q;
  logic [TrackPtrWidth:0]   count_q, count_d;
  group_mask_t              head_mask;
  group_mask_t              avail;    // Group has a done for the head record
  logic                     head_valid;
  logic                     retire;
  dma_meta_t                meta_q, meta_d;

  assign full_o     = (count_q == TrackDepth);
  assign head_valid = (count_q != '0);
  assign head_mask  = mask_mem[rd_ptr_q];
  assign retire     = head_valid && ((head_mask & ~avail) == '0);
  assign count_d    = count_q + (TrackPtrWidth+1)'(push_i) - (TrackPtrWidth+1)'(retire);

  // Dones not yet used, one counter per group
  for (genvar g = 0; g < NumGroups; g++) begin : gen_done_cnt
    logic [TrackCntWidth-1:0] cnt_q;
    logic                     take;

    assign take     = retire && head_mask[g];
    assign avail[g] = (cnt_q != '0) || group_done_i[g]; // Same-cycle done counts too

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        cnt_q <= '0;
      end else begin
        cnt_q <= cnt_q + TrackCntWidth'(group_done_i[g]) - TrackCntWidth'(take);
      end
    end

    a_cnt_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      group_done_i[g] && !take |-> cnt_q != '1);
  end : gen_done_cnt

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (retire) rd_ptr_q <= rd_ptr_q + 1'b1;
      count_q <= count_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mask_mem[wr_ptr_q] <= mask_i;
      last_mem[wr_ptr_q] <= last_i;
    end
  end

  assign meta_d.trans_complete = retire && last_mem[rd_ptr_q];
  assign meta_d.backend_idle   = (count_d == '0) && !busy_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      meta_q <= '{trans_complete: 1'b0, backend_idle: 1'b1};
    end else begin
      meta_q <= meta_d;
    end
  end

  assign dma_meta_o = meta_q;

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    full_o |-> !push_i);

endmodule : dma_completion_tracker

`default_nettype wire

//--- design/dma_cluster_frontend.sv
/* DMA front end of the shared-L1 cluster
   Splits L2 transfers into rows and group stripes and collects completions */
`timescale 1ns/1ps
`default_nettype none

module dma_cluster_frontend (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  dma_cluster_pkg::dma_req_t    dma_req_i,
  input  logic                         dma_req_valid_i,
  output logic                         dma_req_ready_o,
  output dma_cluster_pkg::dma_req_t [dma_cluster_pkg::NumGroups-1:0] group_req_o,
  output dma_cluster_pkg::group_mask_t group_valid_o,
  input  dma_cluster_pkg::group_mask_t group_ready_i,
  input  dma_cluster_pkg::group_mask_t group_done_i,
  output dma_cluster_pkg::dma_meta_t   dma_meta_o
);
  import dma_cluster_pkg::*;

  dma_req_t                 req_cut;
  logic                     req_cut_valid, req_cut_ready;
  dma_row_piece_t           row_piece;
  logic                     row_valid, row_ready;
  dma_req_t [NumGroups-1:0] grp_req;
  group_mask_t              grp_valid, grp_ready;
  logic                     track_push, track_last, track_full;
  group_mask_t              track_mask;
  logic                     busy;

  dma_spill_reg i_req_cut (
    .clk_i, .rst_n_i,
    .data_i (dma_req_i),     .valid_i(dma_req_valid_i), .ready_o(dma_req_ready_o),
    .data_o (req_cut),       .valid_o(req_cut_valid),   .ready_i(req_cut_ready)
  );

  dma_row_splitter i_row_splitter (
    .clk_i, .rst_n_i,
    .req_i   (req_cut),   .req_valid_i  (req_cut_valid), .req_ready_o  (req_cut_ready),
    .piece_o (row_piece), .piece_valid_o(row_valid),     .piece_ready_i(row_ready)
  );

  dma_group_distributor i_group_distributor (
    .clk_i, .rst_n_i,
    .piece_i      (row_piece), .piece_valid_i(row_valid), .piece_ready_o(row_ready),
    .group_req_o  (grp_req),   .group_valid_o(grp_valid), .group_ready_i(grp_ready),
    .track_push_o (track_push),
    .track_mask_o (track_mask),
    .track_last_o (track_last),
    .track_full_i (track_full)
  );

  // Anything still moving ahead of the tracker keeps the backend busy
  assign busy = req_cut_valid || row_valid || (|grp_valid) || (|group_valid_o);

  dma_completion_tracker i_completion_tracker (
    .clk_i, .rst_n_i,
    .push_i (track_push), .mask_i(track_mask), .last_i(track_last), .full_o(track_full),
    .group_done_i, .busy_i(busy), .dma_meta_o
  );

  for (genvar g = 0; g < NumGroups; g++) begin : gen_group_cut
    dma_spill_reg i_group_cut (
      .clk_i, .rst_n_i,
      .data_i (grp_req[g]),     .valid_i(grp_valid[g]),     .ready_o(grp_ready[g]),
      .data_o (group_req_o[g]), .valid_o(group_valid_o[g]), .ready_i(group_ready_i[g])
    );
  end : gen_group_cut

  // Geometry checks
  if (NumGroups != 2**GroupIdxWidth)
    $fatal(1, "[dma_cluster] The number of groups must be a power of two.");
  if (RowBytes != 2**$clog2(RowBytes))
    $fatal(1, "[dma_cluster] The row size must be a power of two.");
  if ((TcdmBaseAddr % RowBytes) != 0 || (TcdmSize % RowBytes) != 0)
    $fatal(1, "[dma_cluster] The TCDM region must be row aligned.");
  if (TrackDepth != 2**TrackPtrWidth)
    $fatal(1, "[dma_cluster] The tracker depth must be a power of two.");

endmodule : dma_cluster_frontend

`default_nettype wire

//--- test/tb_clk_gen.sv
/* Testbench clock source with a 100 ns period */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o
);
  localparam time HalfPeriod = 50ns;

  initial begin
    clk_o = 1'b0;
    forever #(HalfPeriod) clk_o = ~clk_o;
  end

endmodule : tb_clk_gen

`default_nettype wire

//--- test/tb_dma_cluster_frontend.sv
/* Testbench of the DMA cluster front end
   Random transfers against a group model and a reference model of the row and stripe cuts */
`timescale 1ns/1ps
`default_nettype none

module tb_dma_cluster_frontend;
  import dma_cluster_pkg::*;

  localparam int unsigned NumTrans       = 40;
  localparam int unsigned MaxLen         = 300;
  localparam int unsigned Seed           = 51;
  localparam int unsigned StallStart     = 15;  // Transfer index that opens the long stall
  localparam int unsigned StallCycles    = 60;
  localparam int unsigned IdleCycles     = 20;
  localparam int unsigned WatchdogCycles = NumTrans * MaxLen * 4;
  localparam dma_meta_t   IdleMeta       = '{trans_complete: 1'b0, backend_idle: 1'b1};

  logic                     clk_i;
  logic                     rst_n_i;
  dma_req_t                 dma_req_i;
  logic                     dma_req_valid_i;
  logic                     dma_req_ready_o;
  dma_req_t [NumGroups-1:0] group_req_o;
  group_mask_t              group_valid_o;
  group_mask_t              group_ready_i;
  group_mask_t              group_done_i;
  dma_meta_t                dma_meta_o;

  logic [31:0] rng = Seed;
  dma_req_t    trans [NumTrans];
  int unsigned pieces_left [NumTrans];   // Group pieces still waiting for a done
  dma_req_t    exp_q [NumGroups][$];
  int unsigned exp_tid [NumGroups][$];
  int unsigned done_due [NumGroups][$];
  int unsigned done_tid [NumGroups][$];
  int unsigned last_due [NumGroups];
  logic        held_v [NumGroups];
  dma_req_t    held_d [NumGroups];
  int unsigned cycle, next_tx, sent, cpl_idx, idle_cycles, stall_left;
  logic        in_valid, req_taken, stall_done, saw_ready_low, saw_ready_back;

  tb_clk_gen clk_gen_inst (.clk_o(clk_i));

  dma_cluster_frontend dma_cluster_frontend_inst (
    .clk_i, .rst_n_i, .dma_req_i, .dma_req_valid_i, .dma_req_ready_o,
    .group_req_o, .group_valid_o, .group_ready_i, .group_done_i, .dma_meta_o
  );

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic int unsigned draw(int unsigned bound);
    rng = xorshift32(rng);
    return rng % bound;
  endfunction

  task automatic fail_run();
    $display("Test failed");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_req(string name, dma_req_t got, dma_req_t exp);
    if (got !== exp) begin
      $display("ERROR: %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_meta(string name, dma_meta_t got, dma_meta_t exp);
    if (got !== exp) begin
      $display("ERROR: %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_mask(string name, group_mask_t got, group_mask_t exp);
    if (got !== exp) begin
      $display("ERROR: %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  task automatic check_group_idx(string name, logic [GroupIdxWidth-1:0] got,
                                 logic [GroupIdxWidth-1:0] exp);
    if (got !== exp) begin
      $display("ERROR: %s got %h expected %h", name, got, exp);
      fail_run();
    end
  endtask

  // Row cut first, then stripe cut, each stripe owned by one group
  task automatic build_pieces(int unsigned t);
    dma_req_t    piece;
    addr_t       src, dst;
    int unsigned left, row_len, step, g;
    src = trans[t].src;
    dst = trans[t].dst;
    left = trans[t].num_bytes;
    pieces_left[t] = 0;
    while (left > 0) begin
      row_len = RowBytes - (dst % RowBytes);
      if (left < row_len) row_len = left;
      left -= row_len;
      while (row_len > 0) begin
        step = GroupBytes - (dst % GroupBytes);
        if (row_len < step) step = row_len;
        g = (dst / GroupBytes) % NumGroups;
        piece = '{src: src, dst: dst, num_bytes: len_t'(step)};
        exp_q[g].push_back(piece);
        exp_tid[g].push_back(t);
        pieces_left[t]++;
        src += step;
        dst += step;
        row_len -= step;
      end
    end
  endtask

  task automatic accept_piece(int unsigned g);
    dma_req_t    got;
    int unsigned due;
    got = group_req_o[g];
    if (exp_q[g].size() == 0) begin
      $display("Group %0d received a piece that the model does not expect", g);
      fail_run();
    end
    check_group_idx("group_req_o.dst group", GroupIdxWidth'((got.dst / GroupBytes) % NumGroups),
                    GroupIdxWidth'(g));
    if ((got.dst % GroupBytes) + got.num_bytes > GroupBytes) begin
      $display("A piece on group %0d crosses a group stripe boundary", g);
      fail_run();
    end
    check_req("group_req_o", got, exp_q[g].pop_front());
    due = cycle + 1 + draw(7);  // Dones stay in order per group
    if (due <= last_due[g]) due = last_due[g] + 1;
    last_due[g] = due;
    done_due[g].push_back(due);
    done_tid[g].push_back(exp_tid[g].pop_front());
  endtask

  task automatic run_groups();
    group_mask_t done;
    int unsigned tid;
    done = '0;
    for (int g = 0; g < NumGroups; g++) begin
      if (held_v[g] && !group_valid_o[g]) begin
        $display("Group %0d lost its valid before the word was taken", g);
        fail_run();
      end
      if (held_v[g]) check_req("group_req_o", group_req_o[g], held_d[g]);
      if (done_due[g].size() != 0 && done_due[g][0] <= cycle) begin
        done[g] = 1'b1;
        void'(done_due[g].pop_front());
        tid = done_tid[g].pop_front();
        pieces_left[tid]--;
      end
      group_ready_i[g] = (stall_left == 0) && (draw(4) != 0);
      if (group_valid_o[g] && group_ready_i[g]) accept_piece(g);
      held_v[g] = group_valid_o[g] && !group_ready_i[g];
      held_d[g] = group_req_o[g];
    end
    group_done_i = done;
  endtask

  task automatic check_status();
    if (dma_meta_o.trans_complete) begin
      if (cpl_idx >= NumTrans || pieces_left[cpl_idx] != 0) begin
        $display("A completion pulse came before all pieces of transfer %0d were done", cpl_idx);
        fail_run();
      end
      cpl_idx++;
    end
    if (cpl_idx == NumTrans) begin
      if (idle_cycles != 0) check_meta("dma_meta_o", dma_meta_o, IdleMeta);
      if (dma_meta_o.backend_idle) idle_cycles++;
    end
  endtask

  task automatic drive_input();
    if (req_taken) begin
      sent++;
      in_valid = 1'b0;
    end
    if (!in_valid && next_tx < NumTrans && draw(4) != 0) begin
      dma_req_i = trans[next_tx];
      in_valid = 1'b1;
      next_tx++;
    end
    if (stall_left != 0) begin
      if (!dma_req_ready_o) saw_ready_low = 1'b1;
      stall_left--;
      stall_done = (stall_left == 0);
    end else if (!stall_done && next_tx == StallStart) begin
      stall_left = StallCycles;
    end
    if (stall_done && saw_ready_low && dma_req_ready_o) saw_ready_back = 1'b1;
    dma_req_valid_i = in_valid;
    req_taken = in_valid && dma_req_ready_o;  // Taken at the coming rising edge
  endtask

  initial begin
    rst_n_i         = 1'b0;
    dma_req_i       = '0;
    dma_req_valid_i = 1'b0;
    group_ready_i   = '0;
    group_done_i    = '0;
    {cycle, next_tx, sent, cpl_idx, idle_cycles, stall_left} = '0;
    {in_valid, req_taken, stall_done, saw_ready_low, saw_ready_back} = '0;
    for (int g = 0; g < NumGroups; g++) begin
      last_due[g] = 0;
      held_v[g] = 1'b0;
    end
    for (int t = 0; t < NumTrans; t++) begin
      trans[t].dst       = TcdmBaseAddr + draw(TcdmSize - MaxLen);
      trans[t].src       = addr_t'(draw(32'hffff_ffff));
      trans[t].num_bytes = len_t'(1 + draw(MaxLen));
      build_pieces(t);
    end
    repeat (2) begin
      @(negedge clk_i);
      check_mask("group_valid_o", group_valid_o, '0);
      check_meta("dma_meta_o", dma_meta_o, IdleMeta);
    end
    rst_n_i = 1'b1;
    @(negedge clk_i);
    check_mask("group_valid_o", group_valid_o, '0);
    check_meta("dma_meta_o", dma_meta_o, IdleMeta);
    while (cpl_idx < NumTrans || idle_cycles < IdleCycles) begin
      @(negedge clk_i);
      cycle++;
      check_status();
      run_groups();
      drive_input();
    end
    for (int g = 0; g < NumGroups; g++) begin
      if (exp_q[g].size() != 0 || done_due[g].size() != 0) begin
        $display("Pieces of group %0d are still missing when the run is idle", g);
        fail_run();
      end
    end
    if (sent != NumTrans) begin
      $display("Only %0d of %0d transfers were accepted", sent, NumTrans);
      fail_run();
    end else if (!saw_ready_low || !saw_ready_back) begin
      $display("dma_req_ready_o did not drop in the long stall and recover after it");
      fail_run();
    end else begin
      $display("Test passed");
      $finish;
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("The run did not finish within %0d cycles", WatchdogCycles);
    fail_run();
  end

endmodule : tb_dma_cluster_frontend

`default_nettype wire

//--- src.f
common/dma_cluster_pkg.sv
dma/dma_spill_reg.sv
dma/dma_row_splitter.sv
dma/dma_group_distributor.sv
dma/dma_completion_tracker.sv
design/dma_cluster_frontend.sv
test/tb_clk_gen.sv
test/tb_dma_cluster_frontend.sv

//--- Bender.yml
package:
  name: dma_cluster_frontend

sources:
  - target: rtl
    files:
      - common/dma_cluster_pkg.sv
      - dma/dma_spill_reg.sv
      - dma/dma_row_splitter.sv
      - dma/dma_group_distributor.sv
      - dma/dma_completion_tracker.sv
      - design/dma_cluster_frontend.sv

  - target: test
    files:
      - test/tb_clk_gen.sv
      - test/tb_dma_cluster_frontend.sv
